// ==== src/csidhPkg.sv ====
`default_nettype none

package csidhPkg;

	localparam int PRIME_COUNT_MAX = 74;

	typedef logic [11:0] primeT;

	// bit 3 is the direction, bits 2..0 the magnitude
	typedef logic [3:0] exponentT;

	typedef logic [2:0] stepCountT;

	typedef logic [PRIME_COUNT_MAX-1:0] primeMaskT;

	// ----------------------------------------------------------
	// small odd primes, ascending
	// ----------------------------------------------------------
	localparam primeT primeTable [0:PRIME_COUNT_MAX-1] = '{
		12'd3,   12'd5,   12'd7,   12'd11,  12'd13,  12'd17,  12'd19,  12'd23,
		12'd29,  12'd31,  12'd37,  12'd41,  12'd43,  12'd47,  12'd53,  12'd59,
		12'd61,  12'd67,  12'd71,  12'd73,  12'd79,  12'd83,  12'd89,  12'd97,
		12'd101, 12'd103, 12'd107, 12'd109, 12'd113, 12'd127, 12'd131, 12'd137,
		12'd139, 12'd149, 12'd151, 12'd157, 12'd163, 12'd167, 12'd173, 12'd179,
		12'd181, 12'd191, 12'd193, 12'd197, 12'd199, 12'd211, 12'd223, 12'd227,
		12'd229, 12'd233, 12'd239, 12'd241, 12'd251, 12'd257, 12'd263, 12'd269,
		12'd271, 12'd277, 12'd281, 12'd283, 12'd293, 12'd307, 12'd311, 12'd313,
		12'd317, 12'd331, 12'd337, 12'd347, 12'd349, 12'd353, 12'd359, 12'd367,
		12'd373, 12'd587
	};

	// one scheduled batch as presented to the isogeny side
	typedef struct packed {
		primeMaskT batchMask;
		primeMaskT dummyMask;
		logic direction;
	} batchInfoT;

endpackage

`default_nettype wire

// ==== src/exponentBank.sv ====
`timescale 1ns/100ps
`default_nettype none

module exponentBank import csidhPkg::*; #(
	parameter int NUM_PRIMES = 74,
	parameter int MAX_STEPS = 5
) (
	input logic clk,
	input logic rst,
	input logic load,
	input logic [4*NUM_PRIMES-1:0] privateKey,
	input logic commit,
	input primeMaskT commitMask,
	output exponentT [NUM_PRIMES-1:0] exponents,
	output stepCountT [NUM_PRIMES-1:0] steps
);

	// ----------------------------------------------------------
	// step counters
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			steps <= '0;
		end else if (load) begin
			for (int i = 0; i < NUM_PRIMES; i++) begin
				steps[i] <= stepCountT'(MAX_STEPS);
			end
		end else if (commit) begin
			for (int i = 0; i < NUM_PRIMES; i++) begin
				if (commitMask[i]) begin
					steps[i] <= steps[i] - 1'b1;
				end
			end
		end
	end

	// ----------------------------------------------------------
	// exponents
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (load) begin
			// prime 0 sits in the top nibble of the key
			for (int i = 0; i < NUM_PRIMES; i++) begin
				exponents[i] <= privateKey[4*(NUM_PRIMES-1-i) +: 4];
			end
		end else if (commit) begin
			for (int i = 0; i < NUM_PRIMES; i++) begin
				// direction bit is left alone, magnitude saturates at 0
				if (commitMask[i] && (exponents[i][2:0] != 3'd0)) begin
					exponents[i][2:0] <= exponents[i][2:0] - 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/batchSelector.sv ====
`timescale 1ns/100ps
`default_nettype none

module batchSelector import csidhPkg::*; #(
	parameter int NUM_PRIMES = 74,
	parameter int BATCH_MAX = 16
) (
	input logic clk,
	input logic rst,
	input logic selReq,
	input logic direction,
	input exponentT [NUM_PRIMES-1:0] exponents,
	input stepCountT [NUM_PRIMES-1:0] steps,
	output logic selDone,
	output logic found,
	output batchInfoT selBatch
);

	localparam int IW = $clog2(NUM_PRIMES + 1);
	localparam int TW = $clog2(BATCH_MAX + 1);

	typedef enum logic [1:0] {SEL_IDLE, SEL_SCAN, SEL_WAIT} selStateT;

	selStateT state;
	logic [IW-1:0] idx;
	logic [TW-1:0] taken;
	logic qualify;
	logic lastPrime;
	logic lastSlot;

	// direction is taken from the latched copy in the batch
	assign qualify = (exponents[idx][3] == selBatch.direction) && (steps[idx] != '0);
	assign lastPrime = (idx == IW'(NUM_PRIMES - 1));
	assign lastSlot = (taken == TW'(BATCH_MAX - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= SEL_IDLE;
			selDone <= 1'b0;
		end else begin
			selDone <= 1'b0;
			case (state)
				SEL_IDLE: begin
					if (selReq) begin
						idx <= '0;
						taken <= '0;
						selBatch <= '{batchMask: '0, dummyMask: '0, direction: direction};
						state <= SEL_SCAN;
					end
				end
				SEL_SCAN: begin
					if (qualify) begin
						selBatch.batchMask[idx] <= 1'b1;
						selBatch.dummyMask[idx] <= (exponents[idx][2:0] == 3'd0);
						taken <= taken + 1'b1;
					end
					if (lastPrime || (qualify && lastSlot)) begin
						selDone <= 1'b1;
						found <= qualify || (taken != '0);
						state <= SEL_WAIT;
					end else begin
						idx <= idx + 1'b1;
					end
				end
				SEL_WAIT: begin
					if (!selReq) begin
						state <= SEL_IDLE;
					end
				end
				default: state <= SEL_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/cofactorMultiplier.sv ====
`timescale 1ns/100ps
`default_nettype none

module cofactorMultiplier import csidhPkg::*; #(
	parameter int unsigned N = 24,
	parameter logic [N-1:0] MODULUS = 1000003
) (
	input logic clk,
	input logic rst,
	input logic mulReq,
	input logic [N-1:0] a,
	input primeT prime,
	output logic mulDone,
	output logic [N-1:0] product
);

	localparam int PW = $bits(primeT);
	localparam int BW = $clog2(PW);
	localparam logic [N:0] MOD_EXT = {1'b0, MODULUS};

	typedef enum logic [1:0] {MUL_IDLE, MUL_RUN, MUL_WAIT} mulStateT;

	mulStateT state;
	logic [BW-1:0] bitIdx;
	logic [N-1:0] aReg;
	primeT primeReg;
	logic [N:0] doubled;
	logic [N:0] doubledRed;
	logic [N:0] sum;
	logic [N:0] sumRed;

	// double then add, each followed by one conditional subtract
	always_comb begin
		doubled = {product, 1'b0};
		doubledRed = (doubled >= MOD_EXT) ? doubled - MOD_EXT : doubled;
		sum = doubledRed + {1'b0, aReg};
		sumRed = (sum >= MOD_EXT) ? sum - MOD_EXT : sum;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= MUL_IDLE;
			mulDone <= 1'b0;
		end else begin
			mulDone <= 1'b0;
			case (state)
				MUL_IDLE: begin
					if (mulReq) begin
						aReg <= a;
						primeReg <= prime;
						product <= '0;
						bitIdx <= BW'(PW - 1);
						state <= MUL_RUN;
					end
				end
				MUL_RUN: begin
					product <= primeReg[bitIdx] ? sumRed[N-1:0] : doubledRed[N-1:0];
					if (bitIdx == '0) begin
						mulDone <= 1'b1;
						state <= MUL_WAIT;
					end else begin
						bitIdx <= bitIdx - 1'b1;
					end
				end
				MUL_WAIT: begin
					if (!mulReq) begin
						state <= MUL_IDLE;
					end
				end
				default: state <= MUL_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/scalarBuilder.sv ====
`timescale 1ns/100ps
`default_nettype none

module scalarBuilder import csidhPkg::*; #(
	parameter int unsigned N = 24,
	parameter logic [N-1:0] MODULUS = 1000003,
	parameter int NUM_PRIMES = 74
) (
	input logic clk,
	input logic rst,
	input logic buildReq,
	input primeMaskT batchMask,
	output logic buildDone,
	output logic [N-1:0] scalar
);

	localparam int IW = $clog2(NUM_PRIMES + 1);

	typedef enum logic [1:0] {BLD_IDLE, BLD_WALK, BLD_MUL, BLD_WAIT} bldStateT;

	bldStateT state;
	logic [IW-1:0] idx;
	logic [N-1:0] acc;
	primeT mulPrime;
	logic mulReq;
	logic mulDone;
	logic [N-1:0] product;

	cofactorMultiplier #(
		.N(N),
		.MODULUS(MODULUS)
	) i_mul (
		.clk(clk),
		.rst(rst),
		.mulReq(mulReq),
		.a(acc),
		.prime(mulPrime),
		.mulDone(mulDone),
		.product(product)
	);

	assign scalar = acc;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= BLD_IDLE;
			buildDone <= 1'b0;
			mulReq <= 1'b0;
		end else begin
			buildDone <= 1'b0;
			case (state)
				BLD_IDLE: begin
					if (buildReq) begin
						// cofactor of the curve order starts at 4
						acc <= N'(4);
						idx <= '0;
						state <= BLD_WALK;
					end
				end
				BLD_WALK: begin
					if (idx == IW'(NUM_PRIMES)) begin
						buildDone <= 1'b1;
						state <= BLD_WAIT;
					end else if (batchMask[idx]) begin
						idx <= idx + 1'b1;
					end else begin
						mulPrime <= primeTable[idx];
						mulReq <= 1'b1;
						state <= BLD_MUL;
					end
				end
				BLD_MUL: begin
					if (mulDone) begin
						acc <= product;
						mulReq <= 1'b0;
						idx <= idx + 1'b1;
						state <= BLD_WALK;
					end
				end
				BLD_WAIT: begin
					if (!buildReq) begin
						state <= BLD_IDLE;
					end
				end
				default: state <= BLD_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/csidhBatchTop.sv ====
`timescale 1ns/100ps
`default_nettype none

module csidhBatchTop import csidhPkg::*; #(
	parameter int unsigned N = 24,
	parameter logic [N-1:0] MODULUS = 1000003,
	parameter int NUM_PRIMES = 74,
	parameter int BATCH_MAX = 16,
	parameter int MAX_STEPS = 5
) (
	input logic clk,
	input logic rst,
	input logic start,
	input logic [4*NUM_PRIMES-1:0] privateKey,
	input logic batchAck,
	output logic batchValid,
	output batchInfoT batch,
	output logic [N-1:0] scalar,
	output logic busy,
	output logic done
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_SELECT,
		ST_BUILD,
		ST_PRESENT,
		ST_COMMIT,
		ST_FINISHED
	} schedStateT;

	schedStateT state;
	logic direction;
	logic loadKey;
	logic commit;
	logic selReq;
	logic selDone;
	logic found;
	batchInfoT selBatch;
	logic buildReq;
	logic buildDone;
	logic [N-1:0] builtScalar;
	exponentT [NUM_PRIMES-1:0] exponents;
	stepCountT [NUM_PRIMES-1:0] steps;

	// key is captured on the accepting edge itself
	assign loadKey = start && !busy;

	exponentBank #(
		.NUM_PRIMES(NUM_PRIMES),
		.MAX_STEPS(MAX_STEPS)
	) i_bank (
		.clk(clk),
		.rst(rst),
		.load(loadKey),
		.privateKey(privateKey),
		.commit(commit),
		.commitMask(batch.batchMask),
		.exponents(exponents),
		.steps(steps)
	);

	batchSelector #(
		.NUM_PRIMES(NUM_PRIMES),
		.BATCH_MAX(BATCH_MAX)
	) i_sel (
		.clk(clk),
		.rst(rst),
		.selReq(selReq),
		.direction(direction),
		.exponents(exponents),
		.steps(steps),
		.selDone(selDone),
		.found(found),
		.selBatch(selBatch)
	);

	scalarBuilder #(
		.N(N),
		.MODULUS(MODULUS),
		.NUM_PRIMES(NUM_PRIMES)
	) i_build (
		.clk(clk),
		.rst(rst),
		.buildReq(buildReq),
		.batchMask(batch.batchMask),
		.buildDone(buildDone),
		.scalar(builtScalar)
	);

	// ----------------------------------------------------------
	// schedule FSM
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			batchValid <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
			direction <= 1'b0;
			selReq <= 1'b0;
			buildReq <= 1'b0;
			commit <= 1'b0;
		end else begin
			case (state)
				ST_IDLE, ST_FINISHED: begin
					if (loadKey) begin
						busy <= 1'b1;
						done <= 1'b0;
						direction <= 1'b0;
						state <= ST_SELECT;
					end
				end
				ST_SELECT: begin
					if (selDone) begin
						selReq <= 1'b0;
						if (found) begin
							batch <= selBatch;
							state <= ST_BUILD;
						end else if (!direction) begin
							// sticky, never goes back to 0 within a run
							direction <= 1'b1;
						end else begin
							done <= 1'b1;
							busy <= 1'b0;
							state <= ST_FINISHED;
						end
					end else begin
						selReq <= 1'b1;
					end
				end
				ST_BUILD: begin
					if (buildDone) begin
						buildReq <= 1'b0;
						scalar <= builtScalar;
						batchValid <= 1'b1;
						state <= ST_PRESENT;
					end else begin
						buildReq <= 1'b1;
					end
				end
				ST_PRESENT: begin
					if (batchAck) begin
						batchValid <= 1'b0;
						commit <= 1'b1;
						state <= ST_COMMIT;
					end
				end
				ST_COMMIT: begin
					commit <= 1'b0;
					state <= ST_SELECT;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verification/csidhBatchSva.sv ====
`timescale 1ns/100ps
`default_nettype none

module csidhBatchSva import csidhPkg::*; #(
	parameter int unsigned N = 24
) (
	input logic clk,
	input logic rst,
	input logic start,
	input logic busy,
	input logic batchAck,
	input logic batchValid,
	input batchInfoT batch,
	input logic [N-1:0] scalar,
	input logic done
);

	logic dirOneSeen;

	// set by the first direction 1 batch of a run
	always_ff @(posedge clk) begin
		if (rst || (start && !busy)) begin
			dirOneSeen <= 1'b0;
		end else if (batchValid && batch.direction) begin
			dirOneSeen <= 1'b1;
		end
	end

	payloadHeld: assert property (@(posedge clk) disable iff (rst)
		batchValid && !batchAck |=> batchValid && $stable(batch) && $stable(scalar))
		else $error("batch payload changed before acceptance");

	validNotDone: assert property (@(posedge clk) disable iff (rst)
		!(batchValid && done))
		else $error("batchValid and done high together");

	directionSticky: assert property (@(posedge clk) disable iff (rst)
		batchValid && dirOneSeen |-> batch.direction)
		else $error("batch direction fell back to 0 within a run");

endmodule

bind csidhBatchTop csidhBatchSva #(
	.N(N)
) i_sva (
	.clk(clk),
	.rst(rst),
	.start(start),
	.busy(busy),
	.batchAck(batchAck),
	.batchValid(batchValid),
	.batch(batch),
	.scalar(scalar),
	.done(done)
);

`default_nettype wire

// ==== verification/tbCsidhBatch.sv ====
`timescale 1ns/100ps
`default_nettype none

module tbCsidhBatch import csidhPkg::*; ();

	localparam int unsigned N = 24;
	localparam logic [N-1:0] MODULUS = 24'd1000003;
	localparam int NUM_PRIMES = 8;
	localparam int BATCH_MAX = 3;
	localparam int MAX_STEPS = 2;
	localparam int KEY_W = 4 * NUM_PRIMES;

	logic clk = 1'b0;
	logic rst;
	logic start;
	logic [KEY_W-1:0] privateKey;
	logic batchAck;
	logic batchValid;
	batchInfoT batch;
	logic [N-1:0] scalar;
	logic busy;
	logic done;

	// one entry per key, and one per expected batch
	logic [KEY_W-1:0] keyQ [$];
	int batchCountQ [$];
	logic [79:0] maskQ [$];
	logic [79:0] dummyQ [$];
	logic [79:0] dirQ [$];
	logic [79:0] scalarQ [$];

	int errorCount = 0;
	int checkCount = 0;
	int cycleCount = 0;
	int cycleLimit = 100000;
	logic [31:0] lcgState = 32'd86;

	csidhBatchTop #(
		.N(N),
		.MODULUS(MODULUS),
		.NUM_PRIMES(NUM_PRIMES),
		.BATCH_MAX(BATCH_MAX),
		.MAX_STEPS(MAX_STEPS)
	) i_dut (
		.clk(clk),
		.rst(rst),
		.start(start),
		.privateKey(privateKey),
		.batchAck(batchAck),
		.batchValid(batchValid),
		.batch(batch),
		.scalar(scalar),
		.busy(busy),
		.done(done)
	);

	always #4 clk = ~clk;

	// ----------------------------------------------------------
	// timeout
	// ----------------------------------------------------------
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("run stopped: no result after %0d cycles", cycleCount);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic compareField(input string name, input logic [159:0] got,
			input logic [159:0] want);
		checkCount++;
		assert (got === want) else begin
			$display("CHECK FAILED at %0d ns: %s expected %0h got %0h", $time, name, want, got);
			errorCount++;
		end
	endtask

	task automatic expectTrue(input logic cond, input string what);
		checkCount++;
		assert (cond === 1'b1) else begin
			$display("error at %0d ns: %s", $time, what);
			errorCount++;
		end
	endtask

	task automatic readStimulus(output bit ok);
		int fd;
		int code;
		int count;
		string line;
		logic [63:0] tag;
		logic [KEY_W-1:0] key;
		logic [79:0] m;
		logic [79:0] d;
		logic [79:0] dir;
		logic [79:0] s;
		count = 0;
		ok = 1'b0;
		fd = $fopen("verification/batchStim.txt", "r");
		if (fd != 0) begin
			while (!$feof(fd)) begin
				code = $fgets(line, fd);
				if (code > 0 && $sscanf(line, "%s", tag) == 1) begin
					if (tag == 64'("key")) begin
						code = $sscanf(line, "%s %h", tag, key);
						keyQ.push_back(key);
						count = 0;
					end else if (tag == 64'("batch")) begin
						code = $sscanf(line, "%s %h %h %h %h", tag, m, d, dir, s);
						maskQ.push_back(m);
						dummyQ.push_back(d);
						dirQ.push_back(dir);
						scalarQ.push_back(s);
						count++;
					end else if (tag == 64'("end")) begin
						batchCountQ.push_back(count);
					end
				end
			end
			$fclose(fd);
			ok = (keyQ.size() > 0) && (keyQ.size() == batchCountQ.size());
		end
	endtask

	task automatic waitForBatchOrDone();
		do begin
			@(negedge clk);
		end while (!(batchValid || done));
	endtask

	// payload must hold under random back-pressure until the ack edge
	task automatic holdAndAccept();
		batchInfoT heldBatch;
		logic [N-1:0] heldScalar;
		int idleCycles;
		heldBatch = batch;
		heldScalar = scalar;
		lcgState = lcgNext(lcgState);
		idleCycles = int'(lcgState[18:16]);
		repeat (idleCycles) begin
			@(negedge clk);
			expectTrue(batchValid, "batchValid dropped before the acknowledge");
			compareField("batch", 160'(batch), 160'(heldBatch));
			compareField("scalar", 160'(scalar), 160'(heldScalar));
		end
		batchAck = 1'b1;
		@(negedge clk);
		batchAck = 1'b0;
		compareField("batchValid", 160'(batchValid), 160'(1'b0));
	endtask

	task automatic runTest(input int t, input int first);
		int errorsBefore;
		errorsBefore = errorCount;
		@(negedge clk);
		start = 1'b1;
		privateKey = keyQ[t];
		@(negedge clk);
		start = 1'b0;
		compareField("busy", 160'(busy), 160'(1'b1));
		compareField("done", 160'(done), 160'(1'b0));
		for (int b = 0; b < batchCountQ[t]; b++) begin
			waitForBatchOrDone();
			expectTrue(batchValid, "run ended before every expected batch was presented");
			if (!batchValid) begin
				break;
			end
			compareField("batchMask", 160'(batch.batchMask), 160'(maskQ[first+b]));
			compareField("dummyMask", 160'(batch.dummyMask), 160'(dummyQ[first+b]));
			compareField("direction", 160'(batch.direction), 160'(dirQ[first+b]));
			compareField("scalar", 160'(scalar), 160'(scalarQ[first+b]));
			compareField("done", 160'(done), 160'(1'b0));
			holdAndAccept();
		end
		waitForBatchOrDone();
		expectTrue(!batchValid, "a batch was presented after the last expected one");
		compareField("done", 160'(done), 160'(1'b1));
		compareField("busy", 160'(busy), 160'(1'b0));
		$display("test %0d key %h: %0d batches, %0d errors", t + 1, keyQ[t],
			batchCountQ[t], errorCount - errorsBefore);
	endtask

	// ----------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------
	initial begin
		bit stimOk;
		int first;
		int budget;
		rst = 1'b1;
		start = 1'b0;
		privateKey = '0;
		batchAck = 1'b0;
		readStimulus(stimOk);
		if (!stimOk) begin
			$display("could not read the stimulus file verification/batchStim.txt");
			$display("TEST RESULT: FAIL");
			$finish;
		end else begin
			budget = 20;
			foreach (batchCountQ[t]) begin
				budget += batchCountQ[t] * (2 * (NUM_PRIMES + 1) + NUM_PRIMES * 14 + 8);
				// two empty scans close each run
				budget += 4 * (NUM_PRIMES + 1);
			end
			cycleLimit = 2 * budget;

			repeat (4) @(posedge clk);
			@(negedge clk);
			rst = 1'b0;
			@(negedge clk);
			compareField("batchValid", 160'(batchValid), 160'(1'b0));
			compareField("busy", 160'(busy), 160'(1'b0));
			compareField("done", 160'(done), 160'(1'b0));
			// stray ack while idle
			batchAck = 1'b1;
			@(negedge clk);
			batchAck = 1'b0;
			@(negedge clk);
			compareField("batchValid", 160'(batchValid), 160'(1'b0));
			compareField("busy", 160'(busy), 160'(1'b0));
			$display("test 0 reset state: %0d errors", errorCount);

			first = 0;
			foreach (keyQ[t]) begin
				runTest(t, first);
				first += batchCountQ[t];
			end

			$display("%0d tests, %0d checks, %0d errors", keyQ.size() + 1, checkCount,
				errorCount);
			if (errorCount == 0) begin
				$display("TEST RESULT: PASS");
			end else begin
				$display("TEST RESULT: FAIL");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== verification/batchStim.txt ====
# key <privateKey hex, prime 0 in the top nibble>, then one line per batch
# batch <batchMask> <dummyMask> <direction> <scalar>, all hex, and end after the last batch
key 2901A384
batch 0d 04 0 e36d1
batch 0d 0c 0 e36d1
batch a0 00 0 22751
batch a0 00 0 22751
batch 52 40 1 58344
batch 52 42 1 58344
end
key 898F89A8
batch 07 05 1 3ce20
batch 07 07 1 3ce20
batch 38 10 1 2ccf4
batch 38 30 1 2ccf4
batch c0 80 1 05219
batch c0 80 1 05219
end
key 12300172
batch 07 00 0 3ce20
batch 07 01 0 3ce20
batch 38 18 0 2ccf4
batch 38 38 0 2ccf4
batch c0 00 0 05219
batch c0 00 0 05219
end
key 90B8C958
batch 42 02 0 aa168
batch 42 02 0 aa168
batch 0d 08 1 e36d1
batch 0d 09 1 e36d1
batch b0 80 1 156e4
batch b0 a0 1 156e4
end

// ==== sim.f ====
src/csidhPkg.sv
src/exponentBank.sv
src/batchSelector.sv
src/cofactorMultiplier.sv
src/scalarBuilder.sv
src/csidhBatchTop.sv
verification/csidhBatchSva.sv
verification/tbCsidhBatch.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tbCsidhBatch
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST RESULT: FAIL" $(LOG); then \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
